/* flist.f */
src/core_types_pkg.sv
src/iq_pkg.sv
src/iq_entries_if.sv
src/iq_dispatch_alloc.sv
src/iq_issue_select.sv
src/iq_entry_array.sv
src/alu_imm_ldu_iq.sv
verification/iq_clk_gen.sv
verification/alu_imm_ldu_iq_assert.sv
verification/alu_imm_ldu_iq_tb.sv

/* run.sh */
#!/bin/sh
# compile and run; exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module alu_imm_ldu_iq_tb -o sim_iq &&
./obj_dir/sim_iq || exit 1

/* src/alu_imm_ldu_iq.sv */
module alu_imm_ldu_iq #(
    parameter int IQ_ENTRIES = 8,
    parameter int DISPATCH_WAYS = 4
) (
    input logic CLK,
    input logic nRST,

    // dispatch by way
    input logic [DISPATCH_WAYS-1:0]                         dispatch_attempt_by_way,
    input logic [DISPATCH_WAYS-1:0]                         dispatch_valid_alu_imm_by_way,
    input logic [DISPATCH_WAYS-1:0]                         dispatch_valid_ldu_by_way,
    input core_types_pkg::op_t [DISPATCH_WAYS-1:0]          dispatch_op_by_way,
    input core_types_pkg::imm12_t [DISPATCH_WAYS-1:0]       dispatch_imm12_by_way,
    input core_types_pkg::pr_t [DISPATCH_WAYS-1:0]          dispatch_A_PR_by_way,
    input logic [DISPATCH_WAYS-1:0]                         dispatch_A_ready_by_way,
    input logic [DISPATCH_WAYS-1:0]                         dispatch_A_is_zero_by_way,
    input core_types_pkg::pr_t [DISPATCH_WAYS-1:0]          dispatch_dest_PR_by_way,
    input core_types_pkg::rob_idx_t [DISPATCH_WAYS-1:0]     dispatch_ROB_index_by_way,

    output logic [DISPATCH_WAYS-1:0]                        dispatch_ack_by_way,

    // pipeline back-pressure
    input logic                                             alu_imm_pipeline_ready,
    input logic                                             ldu_pipeline_ready,

    // writeback bus by bank
    input logic [core_types_pkg::PRF_BANK_COUNT-1:0]        WB_bus_valid_by_bank,
    input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
                                                            WB_bus_upper_PR_by_bank,

    // ALU reg-imm issue
    output logic                        issue_alu_imm_valid,
    output core_types_pkg::op_t         issue_alu_imm_op,
    output core_types_pkg::imm12_t      issue_alu_imm_imm12,
    output logic                        issue_alu_imm_A_forward,
    output logic                        issue_alu_imm_A_is_zero,
    output core_types_pkg::bank_t       issue_alu_imm_A_bank,
    output core_types_pkg::pr_t         issue_alu_imm_dest_PR,
    output core_types_pkg::rob_idx_t    issue_alu_imm_ROB_index,
    output logic                        PRF_alu_imm_req_A_valid,
    output core_types_pkg::pr_t         PRF_alu_imm_req_A_PR,

    // LDU issue
    output logic                        issue_ldu_valid,
    output core_types_pkg::op_t         issue_ldu_op,
    output core_types_pkg::imm12_t      issue_ldu_imm12,
    output logic                        issue_ldu_A_forward,
    output logic                        issue_ldu_A_is_zero,
    output core_types_pkg::bank_t       issue_ldu_A_bank,
    output core_types_pkg::pr_t         issue_ldu_dest_PR,
    output core_types_pkg::rob_idx_t    issue_ldu_ROB_index,
    output logic                        PRF_ldu_req_A_valid,
    output core_types_pkg::pr_t         PRF_ldu_req_A_PR
);

    import iq_pkg::*;

    iq_entry_t [DISPATCH_WAYS-1:0]  dispatch_entry_by_way;
    logic [IQ_ENTRIES-1:0]          dispatch_valid_by_entry;
    iq_entry_t [IQ_ENTRIES-1:0]     dispatch_by_entry;
    logic [IQ_ENTRIES-1:0]          alu_imm_issue_mask;
    logic [IQ_ENTRIES-1:0]          ldu_issue_mask;
    iq_issue_t                      alu_imm_issue;
    iq_issue_t                      ldu_issue;

    iq_entries_if #(.IQ_ENTRIES(IQ_ENTRIES)) entries_if ();

    // per-way ports into entry form
    always_comb begin
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            dispatch_entry_by_way[w].valid_alu_imm = dispatch_valid_alu_imm_by_way[w];
            dispatch_entry_by_way[w].valid_ldu = dispatch_valid_ldu_by_way[w];
            dispatch_entry_by_way[w].op = dispatch_op_by_way[w];
            dispatch_entry_by_way[w].imm12 = dispatch_imm12_by_way[w];
            dispatch_entry_by_way[w].A_PR = dispatch_A_PR_by_way[w];
            dispatch_entry_by_way[w].A_ready = dispatch_A_ready_by_way[w];
            dispatch_entry_by_way[w].A_is_zero = dispatch_A_is_zero_by_way[w];
            dispatch_entry_by_way[w].dest_PR = dispatch_dest_PR_by_way[w];
            dispatch_entry_by_way[w].ROB_index = dispatch_ROB_index_by_way[w];
        end
    end

    // ------------------------------------------------------------
    // allocation, storage, selection

    iq_dispatch_alloc #(
        .IQ_ENTRIES(IQ_ENTRIES),
        .DISPATCH_WAYS(DISPATCH_WAYS)
    ) DISPATCH_ALLOC (
        .dispatch_attempt(dispatch_attempt_by_way),
        .dispatch_entry(dispatch_entry_by_way),
        .entries_if(entries_if.reader),
        .dispatch_ack(dispatch_ack_by_way),
        .dispatch_valid_by_entry(dispatch_valid_by_entry),
        .dispatch_by_entry(dispatch_by_entry)
    );

    iq_entry_array #(.IQ_ENTRIES(IQ_ENTRIES)) ENTRY_ARRAY (
        .CLK(CLK),
        .nRST(nRST),
        .dispatch_valid_by_entry(dispatch_valid_by_entry),
        .dispatch_by_entry(dispatch_by_entry),
        .alu_imm_issue_mask(alu_imm_issue_mask),
        .ldu_issue_mask(ldu_issue_mask),
        .wb_valid_by_bank(WB_bus_valid_by_bank),
        .wb_upper_PR_by_bank(WB_bus_upper_PR_by_bank),
        .entries_if(entries_if.storage)
    );

    iq_issue_select #(.IQ_ENTRIES(IQ_ENTRIES), .LDU_PIPE(0)) ALU_IMM_SELECT (
        .pipeline_ready(alu_imm_pipeline_ready),
        .entries_if(entries_if.reader),
        .issue_valid(issue_alu_imm_valid),
        .issue(alu_imm_issue),
        .prf_req_valid(PRF_alu_imm_req_A_valid),
        .prf_req_PR(PRF_alu_imm_req_A_PR),
        .issue_mask(alu_imm_issue_mask)
    );

    iq_issue_select #(.IQ_ENTRIES(IQ_ENTRIES), .LDU_PIPE(1)) LDU_SELECT (
        .pipeline_ready(ldu_pipeline_ready),
        .entries_if(entries_if.reader),
        .issue_valid(issue_ldu_valid),
        .issue(ldu_issue),
        .prf_req_valid(PRF_ldu_req_A_valid),
        .prf_req_PR(PRF_ldu_req_A_PR),
        .issue_mask(ldu_issue_mask)
    );

    // payloads out to ports
    assign issue_alu_imm_op = alu_imm_issue.op;
    assign issue_alu_imm_imm12 = alu_imm_issue.imm12;
    assign issue_alu_imm_A_forward = alu_imm_issue.A_forward;
    assign issue_alu_imm_A_is_zero = alu_imm_issue.A_is_zero;
    assign issue_alu_imm_A_bank = alu_imm_issue.A_bank;
    assign issue_alu_imm_dest_PR = alu_imm_issue.dest_PR;
    assign issue_alu_imm_ROB_index = alu_imm_issue.ROB_index;

    assign issue_ldu_op = ldu_issue.op;
    assign issue_ldu_imm12 = ldu_issue.imm12;
    assign issue_ldu_A_forward = ldu_issue.A_forward;
    assign issue_ldu_A_is_zero = ldu_issue.A_is_zero;
    assign issue_ldu_A_bank = ldu_issue.A_bank;
    assign issue_ldu_dest_PR = ldu_issue.dest_PR;
    assign issue_ldu_ROB_index = ldu_issue.ROB_index;

endmodule

/* src/core_types_pkg.sv */
package core_types_pkg;

    // physical register file
    parameter int LOG_PR_COUNT = 6;
    parameter int PRF_BANK_COUNT = 4;
    parameter int LOG_PRF_BANK_COUNT = 2;

    // reorder buffer
    parameter int LOG_ROB_ENTRIES = 6;

    // op fields
    parameter int OP_WIDTH = 4;
    parameter int IMM_WIDTH = 12;

    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    // tag without the bank-select bits
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;
    typedef logic [OP_WIDTH-1:0] op_t;
    typedef logic [IMM_WIDTH-1:0] imm12_t;

endpackage

/* src/iq_dispatch_alloc.sv */
module iq_dispatch_alloc #(
    parameter int IQ_ENTRIES = 8,
    parameter int DISPATCH_WAYS = 4
) (
    // dispatch by way
    input logic [DISPATCH_WAYS-1:0]                 dispatch_attempt,
    input iq_pkg::iq_entry_t [DISPATCH_WAYS-1:0]    dispatch_entry,

    // current occupancy
    iq_entries_if.reader                            entries_if,

    output logic [DISPATCH_WAYS-1:0]                dispatch_ack,

    // dispatch routed onto entries
    output logic [IQ_ENTRIES-1:0]                   dispatch_valid_by_entry,
    output iq_pkg::iq_entry_t [IQ_ENTRIES-1:0]      dispatch_by_entry
);

    logic [IQ_ENTRIES-1:0]                      open_mask;
    logic [IQ_ENTRIES-1:0]                      lowest_open;
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0]   chosen_by_way;

    // ------------------------------------------------------------
    // cascaded free-entry pick

    always_comb begin
        // freed this cycle still counts as occupied
        open_mask = ~entries_if.occupied_by_entry;
        lowest_open = '0;
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            lowest_open = open_mask & (~open_mask + 1'b1);
            dispatch_ack[w] = dispatch_attempt[w] & (|open_mask);
            chosen_by_way[w] = lowest_open & {IQ_ENTRIES{dispatch_attempt[w]}};
            open_mask = open_mask & ~chosen_by_way[w];
        end
    end

    // ------------------------------------------------------------
    // way to entry routing

    always_comb begin
        dispatch_valid_by_entry = '0;
        dispatch_by_entry = '0;
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                // at most one way lands on an entry
                if (chosen_by_way[w][e]) begin
                    dispatch_valid_by_entry[e] = 1'b1;
                    dispatch_by_entry[e] = dispatch_entry[w];
                end
            end
        end
    end

endmodule

/* src/iq_entries_if.sv */
interface iq_entries_if #(
    parameter int IQ_ENTRIES = 8
);

    iq_pkg::iq_entry_t [IQ_ENTRIES-1:0] entries;
    logic [IQ_ENTRIES-1:0]              A_forward_by_entry;
    logic [IQ_ENTRIES-1:0]              occupied_by_entry;

    // oldest at bit 0
    logic [IQ_ENTRIES-1:0]              valid_alu_imm_by_entry;
    logic [IQ_ENTRIES-1:0]              valid_ldu_by_entry;

    modport storage (
        output entries, A_forward_by_entry, occupied_by_entry,
        output valid_alu_imm_by_entry, valid_ldu_by_entry
    );

    modport reader (
        input entries, A_forward_by_entry, occupied_by_entry,
        input valid_alu_imm_by_entry, valid_ldu_by_entry
    );

endinterface

/* src/iq_entry_array.sv */
module iq_entry_array #(
    parameter int IQ_ENTRIES = 8
) (
    input logic CLK,
    input logic nRST,

    // incoming dispatch by entry
    input logic [IQ_ENTRIES-1:0]                dispatch_valid_by_entry,
    input iq_pkg::iq_entry_t [IQ_ENTRIES-1:0]   dispatch_by_entry,

    // issue masks from the two selectors
    input logic [IQ_ENTRIES-1:0]                alu_imm_issue_mask,
    input logic [IQ_ENTRIES-1:0]                ldu_issue_mask,

    // writeback bus
    input logic [core_types_pkg::PRF_BANK_COUNT-1:0]    wb_valid_by_bank,
    input core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0]
                                                        wb_upper_PR_by_bank,

    iq_entries_if.storage                       entries_if
);

    import core_types_pkg::*;
    import iq_pkg::*;

    iq_entry_t [IQ_ENTRIES-1:0]     entries_q;
    iq_entry_t [IQ_ENTRIES-1:0]     next_entries;
    iq_entry_t [IQ_ENTRIES+1:0]     source_by_slot;

    logic [IQ_ENTRIES-1:0]          occupied;
    logic [IQ_ENTRIES-1:0]          A_forward;
    bank_t [IQ_ENTRIES-1:0]         A_bank_by_entry;
    upper_pr_t [IQ_ENTRIES-1:0]     A_upper_by_entry;

    // masks are thermometer codes, so the top bit extends upward
    logic [IQ_ENTRIES:0]            alu_imm_mask_ext;
    logic [IQ_ENTRIES:0]            ldu_mask_ext;

    // ------------------------------------------------------------
    // wakeup

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            occupied[i] = entries_q[i].valid_alu_imm | entries_q[i].valid_ldu;
            A_bank_by_entry[i] = entries_q[i].A_PR[LOG_PRF_BANK_COUNT-1:0];
            A_upper_by_entry[i] = entries_q[i].A_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
            // only a waiting operand wakes up
            A_forward[i] = wb_valid_by_bank[A_bank_by_entry[i]]
                & (wb_upper_PR_by_bank[A_bank_by_entry[i]] == A_upper_by_entry[i])
                & ~entries_q[i].A_ready & ~entries_q[i].A_is_zero;
        end
    end

    // ------------------------------------------------------------
    // compaction

    // what each slot offers to the entries below
    always_comb begin
        source_by_slot = '0;
        for (int j = 0; j < IQ_ENTRIES; j++) begin
            if (occupied[j]) begin
                source_by_slot[j] = entries_q[j];
                source_by_slot[j].A_ready = entries_q[j].A_ready | A_forward[j];
            end
            else if (dispatch_valid_by_entry[j]) begin
                source_by_slot[j] = dispatch_by_entry[j];
            end
        end
    end

    assign alu_imm_mask_ext = {alu_imm_issue_mask[IQ_ENTRIES-1], alu_imm_issue_mask};
    assign ldu_mask_ext = {ldu_issue_mask[IQ_ENTRIES-1], ldu_issue_mask};

    // take self, above, or two above
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if ((alu_imm_mask_ext[i] & ldu_mask_ext[i+1])
                | (alu_imm_mask_ext[i+1] & ldu_mask_ext[i])) begin
                next_entries[i] = source_by_slot[i+2];
            end
            else if (alu_imm_mask_ext[i] | ldu_mask_ext[i]) begin
                next_entries[i] = source_by_slot[i+1];
            end
            else begin
                next_entries[i] = source_by_slot[i];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entries_q <= '0;
        end
        else begin
            entries_q <= next_entries;
        end
    end

    // ------------------------------------------------------------
    // state out to allocator and selectors

    always_comb begin
        entries_if.entries = entries_q;
        entries_if.A_forward_by_entry = A_forward;
        entries_if.occupied_by_entry = occupied;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            entries_if.valid_alu_imm_by_entry[i] = entries_q[i].valid_alu_imm;
            entries_if.valid_ldu_by_entry[i] = entries_q[i].valid_ldu;
        end
    end

endmodule

/* src/iq_issue_select.sv */
module iq_issue_select #(
    parameter int IQ_ENTRIES = 8,
    parameter int LDU_PIPE = 0
) (
    input logic                         pipeline_ready,
    iq_entries_if.reader                entries_if,

    // issue to pipe
    output logic                        issue_valid,
    output iq_pkg::iq_issue_t           issue,

    // register read request
    output logic                        prf_req_valid,
    output core_types_pkg::pr_t         prf_req_PR,

    // entries at or above the pick
    output logic [IQ_ENTRIES-1:0]       issue_mask
);

    import core_types_pkg::*;

    logic [IQ_ENTRIES-1:0] valid_for_pipe;
    logic [IQ_ENTRIES-1:0] ready_by_entry;

    assign valid_for_pipe = (LDU_PIPE != 0) ? entries_if.valid_ldu_by_entry
                                            : entries_if.valid_alu_imm_by_entry;

    // operand usable when ready, forwarded this cycle or zero
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            ready_by_entry[i] = pipeline_ready & valid_for_pipe[i]
                & (entries_if.entries[i].A_ready | entries_if.A_forward_by_entry[i]
                   | entries_if.entries[i].A_is_zero);
        end
    end

    // oldest-first pick and payload mux
    always_comb begin
        issue_valid = 1'b0;
        issue = '0;
        prf_req_valid = 1'b0;
        prf_req_PR = '0;
        issue_mask = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (ready_by_entry[i] && !issue_valid) begin
                issue_valid = 1'b1;
                issue.op = entries_if.entries[i].op;
                issue.imm12 = entries_if.entries[i].imm12;
                issue.A_forward = entries_if.A_forward_by_entry[i];
                issue.A_is_zero = entries_if.entries[i].A_is_zero;
                issue.A_bank = entries_if.entries[i].A_PR[LOG_PRF_BANK_COUNT-1:0];
                issue.dest_PR = entries_if.entries[i].dest_PR;
                issue.ROB_index = entries_if.entries[i].ROB_index;
                // no read for a forwarded or zero operand
                prf_req_valid = ~entries_if.A_forward_by_entry[i]
                    & ~entries_if.entries[i].A_is_zero;
                prf_req_PR = entries_if.entries[i].A_PR;
            end
            issue_mask[i] = issue_valid;
        end
    end

endmodule

/* src/iq_pkg.sv */
package iq_pkg;

    // one queue entry
    typedef struct packed {
        logic                       valid_alu_imm;
        logic                       valid_ldu;
        core_types_pkg::op_t        op;
        core_types_pkg::imm12_t     imm12;
        core_types_pkg::pr_t        A_PR;
        logic                       A_ready;
        logic                       A_is_zero;
        core_types_pkg::pr_t        dest_PR;
        core_types_pkg::rob_idx_t   ROB_index;
    } iq_entry_t;

    // payload handed to an issue pipe
    typedef struct packed {
        core_types_pkg::op_t        op;
        core_types_pkg::imm12_t     imm12;
        logic                       A_forward;
        logic                       A_is_zero;
        core_types_pkg::bank_t      A_bank;
        core_types_pkg::pr_t        dest_PR;
        core_types_pkg::rob_idx_t   ROB_index;
    } iq_issue_t;

endpackage

/* verification/alu_imm_ldu_iq_assert.sv */
module alu_imm_ldu_iq_assert #(
    parameter int DISPATCH_WAYS = 4
) (
    input logic                     CLK,
    input logic                     nRST,
    input logic [DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
    input logic [DISPATCH_WAYS-1:0] dispatch_ack_by_way,
    input logic                     alu_imm_pipeline_ready,
    input logic                     ldu_pipeline_ready,
    input logic                     issue_alu_imm_valid,
    input logic                     issue_ldu_valid,
    input logic                     PRF_alu_imm_req_A_valid,
    input logic                     PRF_ldu_req_A_valid
);

    // issue only into a ready pipe
    assert property (@(posedge CLK) disable iff (!nRST)
        issue_alu_imm_valid |-> alu_imm_pipeline_ready);
    assert property (@(posedge CLK) disable iff (!nRST)
        issue_ldu_valid |-> ldu_pipeline_ready);

    // register read only for an issued op
    assert property (@(posedge CLK) disable iff (!nRST)
        PRF_alu_imm_req_A_valid |-> issue_alu_imm_valid);
    assert property (@(posedge CLK) disable iff (!nRST)
        PRF_ldu_req_A_valid |-> issue_ldu_valid);

    assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_ack_by_way & ~dispatch_attempt_by_way) == '0);

    assert property (@(posedge CLK)
        !nRST |-> !(issue_alu_imm_valid | issue_ldu_valid
                    | PRF_alu_imm_req_A_valid | PRF_ldu_req_A_valid));

endmodule

bind alu_imm_ldu_iq alu_imm_ldu_iq_assert #(.DISPATCH_WAYS(DISPATCH_WAYS)) ASSERTIONS (
    .CLK(CLK),
    .nRST(nRST),
    .dispatch_attempt_by_way(dispatch_attempt_by_way),
    .dispatch_ack_by_way(dispatch_ack_by_way),
    .alu_imm_pipeline_ready(alu_imm_pipeline_ready),
    .ldu_pipeline_ready(ldu_pipeline_ready),
    .issue_alu_imm_valid(issue_alu_imm_valid),
    .issue_ldu_valid(issue_ldu_valid),
    .PRF_alu_imm_req_A_valid(PRF_alu_imm_req_A_valid),
    .PRF_ldu_req_A_valid(PRF_ldu_req_A_valid)
);

/* verification/alu_imm_ldu_iq_tb.sv */
module alu_imm_ldu_iq_tb;

    import core_types_pkg::*;
    import iq_pkg::*;

    localparam int IQ_ENTRIES = 8;
    localparam int DISPATCH_WAYS = 4;

    typedef struct packed {
        logic [3:0]     attempt;
        logic [3:0]     ldu_kind;
        logic [3:0]     a_ready;
        logic [3:0]     a_zero;
        pr_t            a_pr_base;
        logic           alu_rdy;
        logic           ldu_rdy;
        logic [3:0]     wb_valid;
        logic [15:0]    wb_upper;
        logic           exp_alu;
        logic           exp_ldu;
    } row_t;

    logic CLK;
    logic nRST;

    logic [DISPATCH_WAYS-1:0]       dispatch_attempt_by_way;
    logic [DISPATCH_WAYS-1:0]       dispatch_valid_alu_imm_by_way;
    logic [DISPATCH_WAYS-1:0]       dispatch_valid_ldu_by_way;
    op_t [DISPATCH_WAYS-1:0]        dispatch_op_by_way;
    imm12_t [DISPATCH_WAYS-1:0]     dispatch_imm12_by_way;
    pr_t [DISPATCH_WAYS-1:0]        dispatch_A_PR_by_way;
    logic [DISPATCH_WAYS-1:0]       dispatch_A_ready_by_way;
    logic [DISPATCH_WAYS-1:0]       dispatch_A_is_zero_by_way;
    pr_t [DISPATCH_WAYS-1:0]        dispatch_dest_PR_by_way;
    rob_idx_t [DISPATCH_WAYS-1:0]   dispatch_ROB_index_by_way;
    logic [DISPATCH_WAYS-1:0]       dispatch_ack_by_way;
    logic                           alu_imm_pipeline_ready;
    logic                           ldu_pipeline_ready;
    logic [PRF_BANK_COUNT-1:0]      WB_bus_valid_by_bank;
    upper_pr_t [PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank;

    logic       issue_alu_imm_valid, issue_alu_imm_A_forward, issue_alu_imm_A_is_zero;
    op_t        issue_alu_imm_op;
    imm12_t     issue_alu_imm_imm12;
    bank_t      issue_alu_imm_A_bank;
    pr_t        issue_alu_imm_dest_PR, PRF_alu_imm_req_A_PR;
    rob_idx_t   issue_alu_imm_ROB_index;
    logic       PRF_alu_imm_req_A_valid;
    logic       issue_ldu_valid, issue_ldu_A_forward, issue_ldu_A_is_zero;
    op_t        issue_ldu_op;
    imm12_t     issue_ldu_imm12;
    bank_t      issue_ldu_A_bank;
    pr_t        issue_ldu_dest_PR, PRF_ldu_req_A_PR;
    rob_idx_t   issue_ldu_ROB_index;
    logic       PRF_ldu_req_A_valid;

    iq_issue_t  alu_act;
    iq_issue_t  ldu_act;

    row_t       rows[$];
    string      names[$];
    iq_entry_t  model_q[$];
    iq_entry_t  driven[DISPATCH_WAYS];
    logic [31:0] lcg_state = 32'ha593;
    int         reset_wait;

    iq_clk_gen CLK_GEN (.CLK(CLK), .nRST(nRST));

    alu_imm_ldu_iq #(.IQ_ENTRIES(IQ_ENTRIES), .DISPATCH_WAYS(DISPATCH_WAYS)) UUT (.*);

    assign alu_act = {issue_alu_imm_op, issue_alu_imm_imm12, issue_alu_imm_A_forward,
        issue_alu_imm_A_is_zero, issue_alu_imm_A_bank, issue_alu_imm_dest_PR,
        issue_alu_imm_ROB_index};
    assign ldu_act = {issue_ldu_op, issue_ldu_imm12, issue_ldu_A_forward,
        issue_ldu_A_is_zero, issue_ldu_A_bank, issue_ldu_dest_PR, issue_ldu_ROB_index};

    // ------------------------------------------------------------
    // helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_pr(input string name, input pr_t exp, input pr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_issue(input string name, input iq_issue_t exp, input iq_issue_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic add_row(input string name, input logic [3:0] attempt, ldu_kind, a_ready,
                           a_zero, input pr_t a_pr_base, input logic alu_rdy, ldu_rdy,
                           input logic [3:0] wb_valid, input logic [15:0] wb_upper,
                           input logic exp_alu, exp_ldu);
        names.push_back(name);
        rows.push_back({attempt, ldu_kind, a_ready, a_zero, a_pr_base, alu_rdy, ldu_rdy,
                        wb_valid, wb_upper, exp_alu, exp_ldu});
    endtask

    // expected payload from a queued op
    function automatic iq_issue_t make_issue(input iq_entry_t e, input logic fwd);
        iq_issue_t p;
        p.op = e.op;
        p.imm12 = e.imm12;
        p.A_forward = fwd;
        p.A_is_zero = e.A_is_zero;
        p.A_bank = e.A_PR[1:0];
        p.dest_PR = e.dest_PR;
        p.ROB_index = e.ROB_index;
        return p;
    endfunction

    task automatic drive_row(input row_t r);
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            lcg_state = lcg_next(lcg_state);
            driven[w].valid_alu_imm = ~r.ldu_kind[w];
            driven[w].valid_ldu = r.ldu_kind[w];
            driven[w].op = lcg_state[27:24];
            driven[w].imm12 = lcg_state[23:12];
            driven[w].A_PR = r.a_pr_base + pr_t'(w);
            driven[w].A_ready = r.a_ready[w];
            driven[w].A_is_zero = r.a_zero[w];
            driven[w].dest_PR = lcg_state[11:6];
            driven[w].ROB_index = lcg_state[5:0];
            dispatch_valid_alu_imm_by_way[w] = driven[w].valid_alu_imm;
            dispatch_valid_ldu_by_way[w] = driven[w].valid_ldu;
            dispatch_op_by_way[w] = driven[w].op;
            dispatch_imm12_by_way[w] = driven[w].imm12;
            dispatch_A_PR_by_way[w] = driven[w].A_PR;
            dispatch_A_ready_by_way[w] = driven[w].A_ready;
            dispatch_A_is_zero_by_way[w] = driven[w].A_is_zero;
            dispatch_dest_PR_by_way[w] = driven[w].dest_PR;
            dispatch_ROB_index_by_way[w] = driven[w].ROB_index;
        end
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            WB_bus_upper_PR_by_bank[b] = r.wb_upper[b*4 +: 4];
        end
        dispatch_attempt_by_way = r.attempt;
        WB_bus_valid_by_bank = r.wb_valid;
        alu_imm_pipeline_ready = r.alu_rdy;
        ldu_pipeline_ready = r.ldu_rdy;
    endtask

    // ------------------------------------------------------------
    // reference model checks one cycle and then steps past the edge

    task automatic check_and_advance(input string name, input row_t r);
        logic [DISPATCH_WAYS-1:0] exp_ack;
        logic fwd[IQ_ENTRIES];
        int alu_idx;
        int ldu_idx;
        int lower;
        int free;
        int b;
        exp_ack = '0;
        alu_idx = -1;
        ldu_idx = -1;
        lower = 0;
        free = IQ_ENTRIES - model_q.size();
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            exp_ack[w] = r.attempt[w] && (free > lower);
            if (r.attempt[w]) lower++;
            check_bit($sformatf("%s ack%0d", name, w), exp_ack[w], dispatch_ack_by_way[w]);
        end
        for (int i = 0; i < model_q.size(); i++) begin
            b = int'(model_q[i].A_PR[1:0]);
            fwd[i] = r.wb_valid[b] && (r.wb_upper[b*4 +: 4] == model_q[i].A_PR[5:2])
                && !model_q[i].A_ready && !model_q[i].A_is_zero;
            if (model_q[i].A_ready || fwd[i] || model_q[i].A_is_zero) begin
                if (alu_idx < 0 && r.alu_rdy && model_q[i].valid_alu_imm) alu_idx = i;
                if (ldu_idx < 0 && r.ldu_rdy && model_q[i].valid_ldu) ldu_idx = i;
            end
        end
        if (((alu_idx >= 0) != r.exp_alu) || ((ldu_idx >= 0) != r.exp_ldu)) begin
            $display("table and reference model disagree on issue in row %s", name);
            stop_on_error();
        end
        check_bit({name, " alu valid"}, r.exp_alu, issue_alu_imm_valid);
        check_bit({name, " ldu valid"}, r.exp_ldu, issue_ldu_valid);
        if (alu_idx >= 0) begin
            check_issue({name, " alu"}, make_issue(model_q[alu_idx], fwd[alu_idx]), alu_act);
            check_bit({name, " alu req"}, !fwd[alu_idx] && !model_q[alu_idx].A_is_zero,
                      PRF_alu_imm_req_A_valid);
            if (!fwd[alu_idx] && !model_q[alu_idx].A_is_zero)
                check_pr({name, " alu req PR"}, model_q[alu_idx].A_PR, PRF_alu_imm_req_A_PR);
        end
        else check_bit({name, " alu req"}, 1'b0, PRF_alu_imm_req_A_valid);
        if (ldu_idx >= 0) begin
            check_issue({name, " ldu"}, make_issue(model_q[ldu_idx], fwd[ldu_idx]), ldu_act);
            check_bit({name, " ldu req"}, !fwd[ldu_idx] && !model_q[ldu_idx].A_is_zero,
                      PRF_ldu_req_A_valid);
            if (!fwd[ldu_idx] && !model_q[ldu_idx].A_is_zero)
                check_pr({name, " ldu req PR"}, model_q[ldu_idx].A_PR, PRF_ldu_req_A_PR);
        end
        else check_bit({name, " ldu req"}, 1'b0, PRF_ldu_req_A_valid);

        @(posedge CLK);
        for (int i = 0; i < model_q.size(); i++) begin
            model_q[i].A_ready = model_q[i].A_ready | fwd[i];
        end
        // remove the younger pick first so the other index stays put
        for (int i = IQ_ENTRIES - 1; i >= 0; i--) begin
            if (i == alu_idx || i == ldu_idx) model_q.delete(i);
        end
        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            if (exp_ack[w]) model_q.push_back(driven[w]);
        end
    endtask

    // ------------------------------------------------------------

    initial begin
        dispatch_attempt_by_way = '0;
        dispatch_valid_alu_imm_by_way = '0;
        dispatch_valid_ldu_by_way = '0;
        dispatch_op_by_way = '0;
        dispatch_imm12_by_way = '0;
        dispatch_A_PR_by_way = '0;
        dispatch_A_ready_by_way = '0;
        dispatch_A_is_zero_by_way = '0;
        dispatch_dest_PR_by_way = '0;
        dispatch_ROB_index_by_way = '0;
        alu_imm_pipeline_ready = 1'b0;
        ldu_pipeline_ready = 1'b0;
        WB_bus_valid_by_bank = '0;
        WB_bus_upper_PR_by_bank = '0;

        //       name                att   ldu   rdy   zero  pr     ar lr wbv   wbup    ea el
        add_row("reset_idle",        4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 0, 0);
        add_row("dispatch_four_alu", 4'hf, 4'h0, 4'hf, 4'h0, 6'h08, 1, 1, 4'h0, 16'h0000, 0, 0);
        add_row("alu_order_0",       4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("alu_order_1",       4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("alu_order_2",       4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("alu_order_3",       4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("alu_drained",       4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 0, 0);
        add_row("fill_low",          4'hf, 4'ha, 4'hf, 4'h0, 6'h10, 0, 0, 4'h0, 16'h0000, 0, 0);
        add_row("fill_high",         4'hf, 4'h5, 4'hf, 4'h0, 6'h14, 0, 0, 4'h0, 16'h0000, 0, 0);
        add_row("full_no_ack",       4'h3, 4'h0, 4'hf, 4'h0, 6'h18, 0, 0, 4'h0, 16'h0000, 0, 0);
        add_row("dual_issue_0",      4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 1);
        add_row("dual_issue_refill", 4'hf, 4'h0, 4'hf, 4'h0, 6'h1c, 1, 1, 4'h0, 16'h0000, 1, 1);
        add_row("dual_issue_1",      4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 1);
        add_row("dual_issue_2",      4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 1);
        add_row("alu_tail_0",        4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("alu_tail_1",        4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("wake_dispatch",     4'h1, 4'h0, 4'h0, 4'h0, 6'h2d, 1, 1, 4'h0, 16'h0000, 0, 0);
        add_row("wake_wrong_tag",    4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h2, 16'h00a0, 0, 0);
        add_row("wake_forward",      4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h2, 16'h00b0, 1, 0);
        add_row("bp_dispatch",       4'h1, 4'h0, 4'h0, 4'h0, 6'h2d, 0, 1, 4'h0, 16'h0000, 0, 0);
        add_row("bp_wakeup",         4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 0, 1, 4'h2, 16'h00b0, 0, 0);
        add_row("bp_issue",          4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 1, 0);
        add_row("zero_dispatch",     4'h1, 4'h1, 4'h0, 4'h1, 6'h07, 1, 1, 4'h0, 16'h0000, 0, 0);
        add_row("zero_issue",        4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 0, 1);
        add_row("final_idle",        4'h0, 4'h0, 4'h0, 4'h0, 6'h00, 1, 1, 4'h0, 16'h0000, 0, 0);

        // outputs stay quiet until reset lets go
        reset_wait = 0;
        while (nRST !== 1'b1) begin
            @(negedge CLK);
            #2;
            check_bit("reset alu valid", 1'b0, issue_alu_imm_valid);
            check_bit("reset ldu valid", 1'b0, issue_ldu_valid);
            check_bit("reset alu req", 1'b0, PRF_alu_imm_req_A_valid);
            check_bit("reset ldu req", 1'b0, PRF_ldu_req_A_valid);
            reset_wait++;
            if (reset_wait > 20) begin
                $display("reset was never released");
                stop_on_error();
            end
        end

        for (int r = 0; r < rows.size(); r++) begin
            @(negedge CLK);
            drive_row(rows[r]);
            #2;
            check_and_advance(names[r], rows[r]);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verification/iq_clk_gen.sv */
module iq_clk_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // reset held for two cycles
    initial begin
        nRST = 1'b0;
        repeat (2) @(negedge CLK);
        nRST = 1'b1;
    end

endmodule
